// File: compile.f
+incdir+.
io_pkg.sv
io_regs.sv
spi_master.sv
usec_timer.sv
io_top.sv
tb_clock.sv
io_tb_asserts.sv
io_tb.sv

// File: io_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "io_settings.svh"

module io_tb;

    import io_pkg::*;

    localparam logic [31:0] SEED = 32'd55;
    localparam int RESET_TIMEOUT = 30;
    localparam int BUS_TIMEOUT   = 20;
    localparam int SILENT_WINDOW = 10;
    localparam int POLL_LIMIT    = 40;
    localparam int LED_LOOPS     = 12;
    localparam int HOLE_LOOPS    = 8;
    localparam int TMR_LOOPS     = 4;
    localparam int SPI_LOOPS     = 6;
    localparam int OUT_LOOPS     = 4;

    logic       clk_48;
    logic       rst_n;
    io_req_t    io_req;
    io_rsp_t    io_rsp;
    logic [2:0] led;
    logic       spi_cs;
    logic       spi_clk;
    logic       spi_mosi;
    logic       spi_miso;

    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          silent_count;
    int          cycle_count;

    // SPI slave model state
    logic                 slave_arm;
    logic [`SPI_BITS-1:0] slave_reply;
    logic [`SPI_BITS-1:0] reply_sh;
    logic [`SPI_BITS-1:0] rx_byte;
    int                   rx_bits;

    tb_clock tb_clock_inst (
        .clk_48 (clk_48),
        .rst_n  (rst_n)
    );

    io_top io_top_inst (
        .clk_48   (clk_48),
        .rst_n    (rst_n),
        .io_req   (io_req),
        .io_rsp   (io_rsp),
        .led      (led),
        .spi_cs   (spi_cs),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    // ------------------------------
    // SPI slave model

    // A low spi_clk before this edge means spi_clk rises on it
    always @(posedge clk_48) begin
        if (slave_arm) begin
            reply_sh <= slave_reply;
            spi_miso <= slave_reply[`SPI_BITS-1];
            rx_byte  <= '0;
            rx_bits  <= 0;
        end else if (!spi_clk) begin
            rx_byte  <= {rx_byte[`SPI_BITS-2:0], spi_mosi};
            rx_bits  <= rx_bits + 1;
            reply_sh <= {reply_sh[`SPI_BITS-2:0], 1'b0};
            spi_miso <= reply_sh[`SPI_BITS-2];
        end
    end

    // ------------------------------
    // Timer model

    // Clock edges since reset release
    always @(posedge clk_48) begin
        if (rst_n !== 1'b1) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    // ------------------------------
    // Helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        lcg_state = lcg_next(lcg_state);
        value = lcg_state ^ (lcg_state >> 16);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, expected);
        end
    endtask

    // One request; strobe for a single cycle, then wait for ready
    task automatic bus_access(input logic is_write, input logic [31:0] addr,
                              input logic [31:0] wdata, input int max_wait,
                              output logic [31:0] rdata, output logic got_ready);
        int waited;
        waited = 0;
        got_ready = 1'b0;
        rdata = '0;
        @(posedge clk_48);
        io_req <= '{strobe: 1'b1, write: is_write, addr: addr, wdata: wdata};
        @(posedge clk_48);
        io_req.strobe <= 1'b0;
        while (!got_ready && waited < max_wait) begin
            @(negedge clk_48);
            waited++;
            if (io_rsp.ready) begin
                got_ready = 1'b1;
                rdata = io_rsp.rdata;
            end
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        got;
        bus_access(1'b1, addr, data, BUS_TIMEOUT, unused, got);
        if (!got) begin
            errors++;
            $display("Timeout: no ready for the write to %h at time %0t", addr, $time);
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        logic got;
        bus_access(1'b0, addr, 32'd0, BUS_TIMEOUT, data, got);
        if (!got) begin
            errors++;
            $display("Timeout: no ready for the read from %h at time %0t", addr, $time);
        end
    endtask

    task automatic expect_no_ready(input logic is_write, input logic [31:0] addr,
                                   input logic [31:0] wdata);
        logic [31:0] unused;
        logic        got;
        bus_access(is_write, addr, wdata, SILENT_WINDOW, unused, got);
        if (got) begin
            errors++;
            $display("Ready came back for address %h outside the I/O region", addr);
        end else begin
            silent_count++;
        end
    endtask

    task automatic arm_slave(input logic [`SPI_BITS-1:0] reply);
        @(posedge clk_48);
        slave_reply <= reply;
        slave_arm   <= 1'b1;
        @(posedge clk_48);
        slave_arm <= 1'b0;
    endtask

    function automatic logic is_mapped(input logic [31:0] addr);
        return (addr == `IO_ADDR_LED) || (addr == `IO_ADDR_TMR) ||
               (addr == `IO_ADDR_SPI_CTRL) || (addr == `IO_ADDR_SPI_DATA);
    endfunction

    // ------------------------------
    // Main sequence

    initial begin
        logic [31:0] r;
        logic [31:0] rd;
        logic [31:0] addr;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] delta;
        logic [31:0] st;
        logic        busy;
        int          waited;
        int          n;
        int          c1;
        int          c2;
        int          polls;
        int          assert_fails;

        io_req       = '0;
        spi_miso     = 1'b1;
        slave_arm    = 1'b0;
        slave_reply  = '0;
        lcg_state    = SEED;
        errors       = 0;
        checks       = 0;
        silent_count = 0;

        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk_48);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("Reset was never released");
        end
        @(negedge clk_48);

        // Reset state
        check_value("led", {29'd0, led}, {29'd0, `LED_RESET});
        check_value("spi_cs", {31'd0, spi_cs}, 32'd1);
        check_value("spi_clk", {31'd0, spi_clk}, 32'd1);
        check_value("spi_mosi", {31'd0, spi_mosi}, 32'd1);
        bus_read(`IO_ADDR_LED, rd);
        check_value("rdata led", rd, {29'd0, `LED_RESET});
        bus_read(`IO_ADDR_SPI_CTRL, rd);
        check_value("rdata spi_ctrl", rd, 32'd1);

        // LED writes and readback
        for (int i = 0; i < LED_LOOPS; i++) begin
            draw_random(r);
            bus_write(`IO_ADDR_LED, r);
            check_value("led", {29'd0, led}, {29'd0, r[2:0]});
            bus_read(`IO_ADDR_LED, rd);
            check_value("rdata led", rd, {29'd0, r[2:0]});
        end

        // Holes in the region read as zero
        for (int i = 0; i < HOLE_LOOPS; i++) begin
            draw_random(r);
            if (r[31]) begin
                addr = {4'hC, 20'd0, r[7:2], 2'b00};
            end else begin
                addr = {4'hC, r[27:2], 2'b00};
            end
            if (is_mapped(addr)) begin
                addr = `IO_ADDR_LED + 32'h10;
            end
            bus_read(addr, rd);
            check_value("rdata unmapped", rd, 32'd0);
        end

        // Timer rate against the edge count since reset
        for (int i = 0; i < TMR_LOOPS; i++) begin
            draw_random(r);
            n = 50 + int'(r[27:20]);
            bus_read(`IO_ADDR_TMR, t1);
            c1 = cycle_count;
            repeat (n) @(posedge clk_48);
            bus_read(`IO_ADDR_TMR, t2);
            c2 = cycle_count;
            delta = t2 - t1;
            check_value("usec_count delta", delta,
                        (c2 / `TMR_PRESCALE) - (c1 / `TMR_PRESCALE));
        end

        // SPI transfers against the slave model
        for (int i = 0; i < SPI_LOOPS; i++) begin
            draw_random(r);
            bus_write(`IO_ADDR_SPI_CTRL, 32'd0);
            check_value("spi_cs", {31'd0, spi_cs}, 32'd0);
            arm_slave(r[23:16]);
            bus_write(`IO_ADDR_SPI_DATA, {24'd0, r[15:8]});
            busy = 1'b1;
            polls = 0;
            st = '0;
            while (busy && polls < POLL_LIMIT) begin
                bus_read(`IO_ADDR_SPI_CTRL, st);
                busy = st[1];
                polls++;
            end
            if (busy) begin
                errors++;
                $display("SPI transfer still busy after %0d polls", polls);
            end
            check_value("spi_ctrl cs", {31'd0, st[0]}, 32'd0);
            check_value("slave mosi byte", {24'd0, rx_byte}, {24'd0, r[15:8]});
            check_value("slave bit count", rx_bits, `SPI_BITS);
            bus_read(`IO_ADDR_SPI_DATA, rd);
            check_value("rdata spi_data", rd, {24'd0, r[23:16]});
            bus_write(`IO_ADDR_SPI_CTRL, 32'd1);
            check_value("spi_cs", {31'd0, spi_cs}, 32'd1);
            check_value("spi_clk", {31'd0, spi_clk}, 32'd1);
        end

        // Outside region C, then a normal request
        for (int i = 0; i < OUT_LOOPS; i++) begin
            draw_random(r);
            addr = r;
            if (addr[31:28] == `IO_REGION) begin
                addr[31:28] = 4'h3;
            end
            expect_no_ready(r[5], addr, r);
            draw_random(r);
            bus_write(`IO_ADDR_LED, r);
            bus_read(`IO_ADDR_LED, rd);
            check_value("rdata led", rd, {29'd0, r[2:0]});
        end

        assert_fails = io_top_inst.io_tb_asserts_inst.assert_fails;
        errors = errors + assert_fails;
        $display("errors=%0d assertion_failures=%0d checks=%0d no_ready=%0d",
                 errors, assert_fails, checks, silent_count);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: io_tb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "io_settings.svh"

module io_tb_asserts (
    input wire logic            clk_48,
    input wire logic            rst_n,
    input wire io_pkg::io_req_t io_req,
    input wire io_pkg::io_rsp_t io_rsp,
    input wire logic            spi_clk
);

    int   assert_fails = 0;
    logic pending;
    logic region_strobe;

    // Only requests inside the region ever get an answer
    assign region_strobe = io_req.strobe && (io_req.addr[31:28] == `IO_REGION);

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= region_strobe || (pending && !io_rsp.ready);
        end
    end

    // ------------------------------
    // Bus handshake

    ready_follows_strobe: assert property (@(posedge clk_48) disable iff (!rst_n)
        $rose(io_rsp.ready) |-> $past(io_req.strobe))
    else begin
        assert_fails++;
        $error("ready rose without a strobe in the previous cycle");
    end

    single_outstanding: assert property (@(posedge clk_48) disable iff (!rst_n)
        io_req.strobe |-> !pending)
    else begin
        assert_fails++;
        $error("strobe issued while a request was still outstanding");
    end

    // ------------------------------
    // SPI clock shape

    spi_clk_low_once: assert property (@(posedge clk_48) disable iff (!rst_n)
        !spi_clk |=> spi_clk)
    else begin
        assert_fails++;
        $error("spi_clk stayed low for two cycles");
    end

endmodule

bind io_top io_tb_asserts io_tb_asserts_inst (
    .clk_48  (clk_48),
    .rst_n   (rst_n),
    .io_req  (io_req),
    .io_rsp  (io_rsp),
    .spi_clk (spi_clk)
);

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_48,
    output logic rst_n
);

    localparam int RESET_CYCLES = 8;

    // 100 ns period
    initial begin
        clk_48 = 1'b0;
        forever #50 clk_48 = ~clk_48;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_48);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: io_top.sv
`timescale 1ns/1ps
`default_nettype none

module io_top (
    input  wire logic            clk_48,
    input  wire logic            rst_n,
    input  wire io_pkg::io_req_t io_req,
    output io_pkg::io_rsp_t      io_rsp,
    output logic [2:0]           led,
    output logic                 spi_cs,
    output logic                 spi_clk,
    output logic                 spi_mosi,
    input  wire logic            spi_miso
);

    import io_pkg::*;

    logic [31:0] usec_count;
    spi_cmd_t    spi_cmd;
    spi_stat_t   spi_stat;

    // ------------------------------
    // Register block

    io_regs io_regs_inst (
        .clk_48     (clk_48),
        .rst_n      (rst_n),
        .io_req     (io_req),
        .io_rsp     (io_rsp),
        .usec_count (usec_count),
        .spi_stat   (spi_stat),
        .spi_cmd    (spi_cmd),
        .led        (led)
    );

    // ------------------------------
    // Microsecond timer

    usec_timer usec_timer_inst (
        .clk_48     (clk_48),
        .rst_n      (rst_n),
        .usec_count (usec_count)
    );

    // ------------------------------
    // SPI master

    spi_master spi_master_inst (
        .clk_48   (clk_48),
        .rst_n    (rst_n),
        .spi_cmd  (spi_cmd),
        .spi_stat (spi_stat),
        .spi_cs   (spi_cs),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

endmodule

`default_nettype wire

// File: usec_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "io_settings.svh"

module usec_timer (
    input  wire logic  clk_48,
    input  wire logic  rst_n,
    output logic [31:0] usec_count
);

    logic [5:0] prescale;
    logic       tick;

    // Last cycle of each microsecond
    assign tick = (prescale == (`TMR_PRESCALE - 6'd1));

    // ------------------------------
    // Prescaler and counter

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            prescale   <= 6'd0;
            usec_count <= 32'd0;
        end else begin
            if (tick) begin
                prescale   <= 6'd0;
                usec_count <= usec_count + 32'd1;
            end else begin
                prescale <= prescale + 6'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: spi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "io_settings.svh"

module spi_master (
    input  wire logic              clk_48,
    input  wire logic              rst_n,
    input  wire io_pkg::spi_cmd_t  spi_cmd,
    output io_pkg::spi_stat_t      spi_stat,
    output logic                   spi_cs,
    output logic                   spi_clk,
    output logic                   spi_mosi,
    input  wire logic              spi_miso
);

    localparam int CNT_W = $clog2(`SPI_BITS + 1);

    logic [CNT_W-1:0]     bit_cnt;
    logic [`SPI_BITS-1:0] shreg;
    logic                 bits_left;

    assign bits_left = (bit_cnt != '0);

    // ------------------------------
    // Chip select, clock and counter

    // Idle bus sits with everything high
    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            spi_cs   <= 1'b1;
            spi_clk  <= 1'b1;
            spi_mosi <= 1'b1;
            bit_cnt  <= '0;
        end else begin
            if (spi_cmd.cs_we) begin
                spi_cs <= spi_cmd.cs_value;
            end

            // Low phase always lasts one cycle
            if (!spi_clk) begin
                spi_clk <= 1'b1;
            end else if (bits_left && !spi_cmd.data_we) begin
                spi_mosi <= shreg[`SPI_BITS-1];
                spi_clk  <= 1'b0;
                bit_cnt  <= bit_cnt - CNT_W'(1);
            end

            // New byte restarts the transfer
            if (spi_cmd.data_we) begin
                bit_cnt <= CNT_W'(`SPI_BITS);
            end
        end
    end

    // ------------------------------
    // Shift register

    // MSB out on the falling edge, MISO in on the rising edge
    always_ff @(posedge clk_48) begin
        if (spi_cmd.data_we) begin
            shreg <= spi_cmd.data;
        end else if (!spi_clk) begin
            shreg[0] <= spi_miso;
        end else if (bits_left) begin
            shreg <= {shreg[`SPI_BITS-2:0], 1'b0};
        end
    end

    // ------------------------------
    // Status

    always_comb begin
        spi_stat.busy  = bits_left || !spi_clk;
        spi_stat.cs    = spi_cs;
        spi_stat.shreg = shreg;
    end

endmodule

`default_nettype wire

// File: io_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "io_settings.svh"

module io_regs (
    input  wire logic              clk_48,
    input  wire logic              rst_n,
    input  wire io_pkg::io_req_t   io_req,
    output io_pkg::io_rsp_t        io_rsp,
    input  wire logic [31:0]       usec_count,
    input  wire io_pkg::spi_stat_t spi_stat,
    output io_pkg::spi_cmd_t       spi_cmd,
    output logic [2:0]             led
);

    import io_pkg::*;

    logic        region_hit;
    logic        write_hit;
    logic [31:0] word_addr;
    logic        rsp_ready;
    logic [31:0] rsp_rdata;
    spi_cmd_t    cmd;

    // ------------------------------
    // Decode

    // Byte lanes are ignored, registers are word-addressed
    assign word_addr  = {io_req.addr[31:2], 2'b00};
    assign region_hit = io_req.strobe && (io_req.addr[31:28] == `IO_REGION);
    assign write_hit  = region_hit && io_req.write;

    // ------------------------------
    // Response

    // Requests outside the region are never answered
    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            rsp_ready <= 1'b0;
        end else begin
            rsp_ready <= region_hit;
        end
    end

    // Address is held by the master until ready, so the mux can stay combinational
    always_comb begin
        rsp_rdata = 32'd0;
        case (word_addr)
            `IO_ADDR_LED: begin
                rsp_rdata = {29'd0, led};
            end
            `IO_ADDR_TMR: begin
                rsp_rdata = usec_count;
            end
            `IO_ADDR_SPI_CTRL: begin
                rsp_rdata = {30'd0, spi_stat.busy, spi_stat.cs};
            end
            `IO_ADDR_SPI_DATA: begin
                rsp_rdata = {{(32 - `SPI_BITS){1'b0}}, spi_stat.shreg};
            end
            default: begin
                rsp_rdata = 32'd0;
            end
        endcase
    end

    assign io_rsp = '{ready: rsp_ready, rdata: rsp_rdata};

    // ------------------------------
    // LED register

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            led <= `LED_RESET;
        end else begin
            if (write_hit && (word_addr == `IO_ADDR_LED)) begin
                led <= io_req.wdata[2:0];
            end
        end
    end

    // ------------------------------
    // SPI commands

    // Taken straight from the strobe cycle so the master acts on the same edge
    always_comb begin
        cmd.cs_we    = write_hit && (word_addr == `IO_ADDR_SPI_CTRL);
        cmd.cs_value = io_req.wdata[0];
        cmd.data_we  = write_hit && (word_addr == `IO_ADDR_SPI_DATA);
        cmd.data     = io_req.wdata[`SPI_BITS-1:0];
    end

    assign spi_cmd = cmd;

endmodule

`default_nettype wire

// File: io_pkg.sv
`default_nettype none

`include "io_settings.svh"

package io_pkg;

    // ------------------------------
    // Processor I/O bus

    // One request, strobe lasts a single cycle
    typedef struct packed {
        logic        strobe;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } io_req_t;

    // Ready follows the strobe by one cycle
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } io_rsp_t;

    // ------------------------------
    // Register block to SPI master

    // Write enables are single-cycle pulses
    typedef struct packed {
        logic                 cs_we;
        logic                 cs_value;
        logic                 data_we;
        logic [`SPI_BITS-1:0] data;
    } spi_cmd_t;

    typedef struct packed {
        logic                 busy;
        logic                 cs;
        logic [`SPI_BITS-1:0] shreg;
    } spi_stat_t;

endpackage

`default_nettype wire

// File: io_settings.svh
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

// ------------------------------
// Address map

// Upper nibble selecting the I/O block
`define IO_REGION 4'hC

// Word addresses of the registers
`define IO_ADDR_LED      32'hC000_0000
`define IO_ADDR_TMR      32'hC000_0004
`define IO_ADDR_SPI_CTRL 32'hC000_0020
`define IO_ADDR_SPI_DATA 32'hC000_0024

// ------------------------------
// Register defaults and rates

// Top LED lit out of reset
`define LED_RESET 3'b100

// clk_48 cycles per microsecond tick
`define TMR_PRESCALE 6'd48

// Bits per SPI transfer
`define SPI_BITS 8

`endif
